// File: hw/cmd_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                              cmd_vld,
  output logic                              cmd_rdy,
  output logic                              tx_start,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte,
  input  logic                              tx_done,
  output logic                              rx_en,
  input  logic                              rx_busy,
  input  logic                              rx_done,
  input  logic                              rx_fault,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_data,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                              read_rdy,
  output logic                              read_err
);

  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_AWAIT,
    S_REPLY
  } seq_state_t;

  seq_state_t                              state;
  logic [CMD_WIDTH-1:0]                    cmd_q;
  logic [$clog2(BIT_CYCLES)-1:0]           cyc_cnt;
  logic [$clog2(REPLY_TIMEOUT_BITS)-1:0]   bit_cnt;
  logic                                    accept;
  logic                                    gap_end;
  logic                                    timeout;
  logic                                    reply_ok;

  assign cmd_rdy = (state == S_IDLE);
  assign rx_en   = (state == S_AWAIT);
  assign accept  = cmd_vld && cmd_rdy;
  assign tx_byte = (state == S_SEND_HI) ? cmd_q[CMD_WIDTH-1:BYTE_WIDTH] : cmd_q[BYTE_WIDTH-1:0];

  // one cycle short, the tx engine spends a cycle loading the next frame
  assign gap_end  = (bit_cnt == GAP_BITS - 1) && (cyc_cnt == BIT_CYCLES - 2);
  assign timeout  = !rx_busy && (bit_cnt == REPLY_TIMEOUT_BITS - 1) &&
                    (cyc_cnt == BIT_CYCLES - 1);
  assign reply_ok = (state == S_AWAIT) && rx_done && !rx_fault;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      cyc_cnt  <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      if (cyc_cnt == BIT_CYCLES - 1)
      begin
        cyc_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            state    <= S_SEND_HI;
            tx_start <= 1'b1;
          end
        end
        S_SEND_HI:
        begin
          if (tx_done)
          begin
            state   <= S_GAP;
            cyc_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        S_GAP:
        begin
          if (gap_end)
          begin
            state    <= S_SEND_LO;
            tx_start <= 1'b1;
          end
        end
        S_SEND_LO:
        begin
          if (tx_done)
          begin
            state   <= cmd_q[WRITE_BIT] ? S_IDLE : S_AWAIT;
            cyc_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        S_AWAIT:
        begin
          if (rx_done)
          begin
            state    <= S_REPLY;
            read_rdy <= !rx_fault;
            read_err <= rx_fault;
          end
          else if (timeout)
          begin
            state    <= S_REPLY;
            read_err <= 1'b1;
          end
          else if (rx_busy)
          begin
            // the timeout only covers the wait for a start bit
            cyc_cnt <= cyc_cnt;
            bit_cnt <= bit_cnt;
          end
        end
        S_REPLY:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (reply_ok)
      read_data <= rx_data;
  end

  a_rdy_err_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(read_rdy && read_err)
  );

  a_start_in_send: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> (state == S_SEND_HI) || (state == S_SEND_LO)
  );

endmodule

`default_nettype wire

// File: hw/uart_cmd_master.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_master (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                              cmd_vld,
  input  logic                              rx,
  output logic                              cmd_rdy,
  output logic                              tx,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                              read_rdy,
  output logic                              read_err
);

  import uart_cmd_pkg::*;

  logic                  tx_start;
  logic [BYTE_WIDTH-1:0] tx_byte;
  logic                  tx_done;
  logic                  rx_en;
  logic                  rx_busy;
  logic [BYTE_WIDTH-1:0] rx_data;
  logic                  rx_done;
  logic                  rx_fault;

  cmd_sequencer i_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_en     (rx_en),
    .rx_busy   (rx_busy),
    .rx_done   (rx_done),
    .rx_fault  (rx_fault),
    .rx_data   (rx_data),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_frame i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_en    (rx_en),
    .rx_busy  (rx_busy),
    .rx_data  (rx_data),
    .rx_done  (rx_done),
    .rx_fault (rx_fault)
  );

endmodule

`default_nettype wire

// File: hw/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // one bit time in clock cycles, 115200 baud from 50 MHz
  localparam int BIT_CYCLES = 434;

  // command word and its fields
  localparam int CMD_WIDTH = 16;
  localparam int BYTE_WIDTH = 8;
  // set for a write, clear for a read
  localparam int WRITE_BIT = 15;

  // frame layout: start, 8 data, even parity, stop
  localparam int FRAME_BITS = 11;

  // idle bit times between high and low command frames
  localparam int GAP_BITS = 2;

  // bit times to wait for the reply start bit
  localparam int REPLY_TIMEOUT_BITS = 24;

endpackage

`default_nettype wire

// File: hw/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              rx,
  input  logic                              rx_en,
  output logic                              rx_busy,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_data,
  output logic                              rx_done,
  output logic                              rx_fault
);

  import uart_cmd_pkg::*;

  typedef enum logic [1:0] {
    R_IDLE,
    R_START,
    R_DATA
  } rx_state_t;

  rx_state_t                       state;
  logic                            rx_s1;
  logic                            rx_s2;
  logic                            rx_s3;
  logic [$clog2(BIT_CYCLES)-1:0]   cyc_cnt;
  logic [$clog2(FRAME_BITS)-1:0]   bit_idx;
  // data bits then parity, LSB first
  logic [BYTE_WIDTH:0]             shreg;
  logic                            fall;
  logic                            sample;

  assign fall    = rx_s3 && !rx_s2;
  assign sample  = (state == R_DATA) && (cyc_cnt == BIT_CYCLES - 1);
  assign rx_busy = (state == R_DATA);

  // stop bit is the last sample of the frame
  assign rx_done  = sample && (bit_idx == FRAME_BITS - 2);
  assign rx_data  = shreg[BYTE_WIDTH-1:0];
  assign rx_fault = (^shreg) || !rx_s2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= R_IDLE;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      case (state)
        R_IDLE:
        begin
          if (rx_en && fall)
          begin
            state   <= R_START;
            cyc_cnt <= '0;
          end
        end
        R_START:
        begin
          // recheck at half a bit, a short glitch goes back to idle
          if (cyc_cnt == BIT_CYCLES / 2 - 1)
          begin
            cyc_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s2 ? R_IDLE : R_DATA;
          end
          else if (!rx_en)
          begin
            state <= R_IDLE;
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        R_DATA:
        begin
          if (sample)
          begin
            cyc_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (rx_done)
              state <= R_IDLE;
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && (bit_idx < FRAME_BITS - 2))
      shreg <= {rx_s2, shreg[BYTE_WIDTH:1]};
  end

  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) rx_done |=> !rx_done
  );

endmodule

`default_nettype wire

// File: hw/uart_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              tx_start,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte,
  output logic                              tx,
  output logic                              tx_done
);

  import uart_cmd_pkg::*;

  logic                            busy;
  logic [$clog2(BIT_CYCLES)-1:0]   cyc_cnt;
  logic [$clog2(FRAME_BITS)-1:0]   bit_cnt;
  // stop, parity and data bits still to go out after the start bit
  logic [BYTE_WIDTH+1:0]           shreg;
  logic                            load;
  logic                            bit_end;

  assign load    = tx_start && !busy;
  assign bit_end = busy && (cyc_cnt == BIT_CYCLES - 1);
  assign tx_done = bit_end && (bit_cnt == FRAME_BITS - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (load)
    begin
      busy    <= 1'b1;
      tx      <= 1'b0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        cyc_cnt <= '0;
        if (tx_done)
        begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end
        else
        begin
          tx      <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  // even parity: total count of ones over data and parity is even
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, ^tx_byte, tx_byte};
    else if (bit_end)
      shreg <= {1'b0, shreg[BYTE_WIDTH+1:1]};
  end

  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !busy
  );

endmodule

`default_nettype wire

// File: src.f
hw/uart_cmd_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/cmd_sequencer.sv
hw/uart_cmd_master.sv
verification/uart_cmd_checker.sv
verification/tb_uart_cmd_master.sv

// File: verification/tb_uart_cmd_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd_master;

  import uart_cmd_pkg::*;

  typedef enum int {
    MODE_WRITE,
    MODE_GOOD,
    MODE_BAD_PARITY,
    MODE_BAD_STOP,
    MODE_SILENT
  } reply_mode_t;

  localparam int NUM_ENTRIES = 8;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES *
    (2 * FRAME_BITS + GAP_BITS + REPLY_TIMEOUT_BITS + FRAME_BITS + 4) * BIT_CYCLES +
    RESET_CYCLES;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  rx;
  logic                  cmd_rdy;
  logic                  tx;
  logic [BYTE_WIDTH-1:0] read_data;
  logic                  read_rdy;
  logic                  read_err;
  logic                  entry_stb;
  logic [CMD_WIDTH-1:0]  entry_cmd;
  logic                  entry_good;
  logic [BYTE_WIDTH-1:0] entry_reply;
  int                    check_count;
  int                    error_count;
  int                    done_count;

  // command word, reply kind, reply byte (good entries get random bytes)
  logic [CMD_WIDTH-1:0]  tbl_cmd   [NUM_ENTRIES];
  reply_mode_t           tbl_mode  [NUM_ENTRIES];
  logic [BYTE_WIDTH-1:0] tbl_reply [NUM_ENTRIES];

  always #20 clk = ~clk;

  uart_cmd_master i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_cmd_checker i_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx          (tx),
    .read_data   (read_data),
    .read_rdy    (read_rdy),
    .read_err    (read_err),
    .entry_stb   (entry_stb),
    .entry_cmd   (entry_cmd),
    .entry_good  (entry_good),
    .entry_reply (entry_reply),
    .check_count (check_count),
    .error_count (error_count),
    .done_count  (done_count)
  );

  // serial reply that starts two bit times after the second command frame
  task automatic send_reply(input reply_mode_t mode, input logic [BYTE_WIDTH-1:0] value);
    logic [FRAME_BITS-1:0] frame;
    int                    k;
    frame = {1'b1, ^value, value, 1'b0};
    if (mode == MODE_BAD_PARITY)
      frame[FRAME_BITS-2] = ~frame[FRAME_BITS-2];
    if (mode == MODE_BAD_STOP)
      frame[FRAME_BITS-1] = 1'b0;
    repeat ((2 * FRAME_BITS + GAP_BITS + 2) * BIT_CYCLES) @(posedge clk);
    for (k = 0; k < FRAME_BITS; k++)
    begin
      rx <= frame[k];
      repeat (BIT_CYCLES) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  // cmd_vld while busy must be ignored
  task automatic pulse_cmd_vld_busy();
    repeat (BIT_CYCLES) @(posedge clk);
    cmd_in  <= 16'hffff;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the stimulus table was finished");
    $display("commands judged: %0d of %0d, checks: %0d, errors: %0d",
             done_count, NUM_ENTRIES, check_count, error_count);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin : stimulus
    int unsigned seed;
    int          i;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    rx          = 1'b1;
    entry_stb   = 1'b0;
    entry_cmd   = '0;
    entry_good  = 1'b0;
    entry_reply = '0;
    tbl_cmd   = '{16'ha53c, 16'h1234, 16'h0a55, 16'h8001,
                  16'h7f00, 16'h0001, 16'h4321, 16'hffff};
    tbl_mode  = '{MODE_WRITE, MODE_GOOD, MODE_BAD_PARITY, MODE_WRITE,
                  MODE_BAD_STOP, MODE_SILENT, MODE_GOOD, MODE_WRITE};
    tbl_reply = '{8'h00, 8'h00, 8'h5a, 8'h00, 8'hc3, 8'h00, 8'h00, 8'h00};
    seed = 32'he463e2f8;
    void'($urandom(seed));
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      if (tbl_mode[i] == MODE_GOOD)
        tbl_reply[i] = $urandom % 256;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      @(posedge clk);
      cmd_in      <= tbl_cmd[i];
      cmd_vld     <= 1'b1;
      entry_stb   <= 1'b1;
      entry_cmd   <= tbl_cmd[i];
      entry_good  <= (tbl_mode[i] == MODE_GOOD);
      entry_reply <= tbl_reply[i];
      do
        @(posedge clk);
      while (!cmd_rdy);
      cmd_vld   <= 1'b0;
      entry_stb <= 1'b0;
      fork
        pulse_cmd_vld_busy();
        if (tbl_mode[i] != MODE_WRITE && tbl_mode[i] != MODE_SILENT)
          send_reply(tbl_mode[i], tbl_reply[i]);
      join
      do
        @(posedge clk);
      while (!cmd_rdy);
      repeat (20) @(posedge clk);
    end
    repeat (20) @(posedge clk);
    $display("commands judged: %0d of %0d, checks: %0d, errors: %0d",
             done_count, NUM_ENTRIES, check_count, error_count);
    if (error_count == 0 && done_count == NUM_ENTRIES)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/uart_cmd_checker.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_checker (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cmd_vld,
  input  logic                                cmd_rdy,
  input  logic                                tx,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  input  logic                                read_rdy,
  input  logic                                read_err,
  input  logic                                entry_stb,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  entry_cmd,
  input  logic                                entry_good,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] entry_reply,
  output int                                  check_count,
  output int                                  error_count,
  output int                                  done_count
);

  import uart_cmd_pkg::*;

  // bytes decoded from tx in order
  logic [BYTE_WIDTH-1:0] tx_bytes[$];
  // reply byte of the last good read, which read_data must hold
  logic [BYTE_WIDTH-1:0] last_good;

  initial
  begin
    check_count = 0;
    error_count = 0;
    done_count  = 0;
    last_good   = '0;
  end

  task automatic note_failure(input string what);
    error_count++;
    $display("%s", what);
  endtask

  task automatic expect_true(input bit ok, input string what);
    check_count++;
    if (!ok)
      note_failure(what);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // called on the first sample of the start bit and returns at mid stop bit
  task automatic decode_frame();
    logic [BYTE_WIDTH-1:0] data;
    logic                  parity;
    int                    k;
    repeat (BIT_CYCLES / 2 - 1) @(posedge clk);
    expect_true(tx == 1'b0, "start bit on tx did not stay low");
    for (k = 0; k < BYTE_WIDTH; k++)
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      data[k] = tx;
    end
    repeat (BIT_CYCLES) @(posedge clk);
    parity = tx;
    compare_value("tx parity bit", parity, $countones(data) % 2);
    repeat (BIT_CYCLES) @(posedge clk);
    expect_true(tx == 1'b1, "stop bit low on tx");
    tx_bytes.push_back(data);
  endtask

  task automatic judge_command(input logic [CMD_WIDTH-1:0] cmd, input logic good,
                               input logic [BYTE_WIDTH-1:0] reply, input int n_rdy,
                               input int n_err, input logic [BYTE_WIDTH-1:0] rdy_data,
                               input int busy_cycles);
    expect_true(tx_bytes.size() == 2,
                $sformatf("expected two tx frames but saw %0d", tx_bytes.size()));
    if (tx_bytes.size() >= 2)
    begin
      compare_value("tx high byte", tx_bytes[0], cmd[CMD_WIDTH-1:BYTE_WIDTH]);
      compare_value("tx low byte", tx_bytes[1], cmd[BYTE_WIDTH-1:0]);
    end
    tx_bytes.delete();
    if (cmd[WRITE_BIT])
    begin
      // two frames and the gap, then one cycle after the last stop bit
      compare_value("cmd_rdy low cycles", busy_cycles,
                    (2 * FRAME_BITS + GAP_BITS) * BIT_CYCLES + 1);
      compare_value("read_rdy pulses", n_rdy, 0);
      compare_value("read_err pulses", n_err, 0);
    end
    else if (good)
    begin
      compare_value("read_rdy pulses", n_rdy, 1);
      compare_value("read_err pulses", n_err, 0);
      compare_value("read_data", rdy_data, reply);
      last_good = reply;
    end
    else
    begin
      compare_value("read_rdy pulses", n_rdy, 0);
      compare_value("read_err pulses", n_err, 1);
      compare_value("read_data", read_data, last_good);
    end
    done_count++;
  endtask

  initial
  begin : tx_decoder
    logic tx_prev;
    tx_prev = 1'b1;
    forever
    begin
      @(posedge clk);
      if (rst_n && tx_prev && !tx)
        decode_frame();
      tx_prev = tx;
    end
  end

  initial
  begin : entry_watch
    logic [CMD_WIDTH-1:0]  cmd;
    logic                  good;
    logic [BYTE_WIDTH-1:0] reply;
    logic [BYTE_WIDTH-1:0] rdy_data;
    int                    n_rdy;
    int                    n_err;
    int                    busy_cycles;
    wait (rst_n === 1'b1);
    @(posedge clk);
    compare_value("tx", tx, 1);
    compare_value("cmd_rdy", cmd_rdy, 1);
    compare_value("read_rdy", read_rdy, 0);
    compare_value("read_err", read_err, 0);
    forever
    begin
      @(posedge clk);
      if (entry_stb && cmd_vld && cmd_rdy)
      begin
        cmd         = entry_cmd;
        good        = entry_good;
        reply       = entry_reply;
        rdy_data    = '0;
        n_rdy       = 0;
        n_err       = 0;
        busy_cycles = 0;
        @(posedge clk);
        expect_true(!cmd_rdy, "cmd_rdy did not fall after the command was accepted");
        while (!cmd_rdy)
        begin
          if (read_rdy)
          begin
            n_rdy++;
            rdy_data = read_data;
          end
          if (read_err)
            n_err++;
          busy_cycles++;
          @(posedge clk);
        end
        judge_command(cmd, good, reply, n_rdy, n_err, rdy_data, busy_cycles);
      end
      else if (read_rdy || read_err)
      begin
        note_failure("read_rdy or read_err pulsed while no command was running");
      end
    end
  end

endmodule

`default_nettype wire
